// ==== rtl/rv_core_pkg.sv ====
/*
 * Shared definitions for the four-stage RV32I core
 *   Data, register index and wrong-path tag widths
 *   RV32I major opcode enum and internal operation enum
 *   Packed structs passed between fetch, decode, execute and retire
 */
`default_nettype none

package rv_core_pkg;

    // Widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 3;

    // Major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OPC_REG    = 7'b0110011,
        OPC_IMM    = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // Operations seen by execute and retire
    // OP_NOP must stay at zero so a cleared register is a bubble
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } op_e;

    // Outstanding fetch, lines up with instruction_i
    typedef struct packed {
        logic [XLEN-1:0]  pc;
        logic [TAG_W-1:0] tag;
    } fetch_out_t;

    // Decode/execute register
    typedef struct packed {
        logic                  valid;
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       pc;
        logic [TAG_W-1:0]      tag;
    } exec_in_t;

    // Register write from retire
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

    // Data memory request from execute
    typedef struct packed {
        logic            read_en;
        logic            write_en;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== rtl/fetch.sv ====
/*
 * Fetch stage
 *   Program counter with sequential advance and jump redirection
 *   Replay of the decode pc on a hazard
 *   Wrong-path tag generation and outstanding fetch register
 */
`default_nettype none

module fetch
    import rv_core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
)
(
    input  logic             clk,
    input  logic             rst_i,
    input  logic             stall_i,
    input  logic             hazard_i,
    input  logic             jump_i,
    input  logic [XLEN-1:0]  jump_target_i,
    input  logic [XLEN-1:0]  replay_pc_i,
    output logic [XLEN-1:0]  instruction_address_o,
    output fetch_out_t       fetch_o
);

    logic [XLEN-1:0]  pc_q;
    logic [TAG_W-1:0] tag_q;

    // Hazard re-presents the decode pc so the same word returns next cycle
    assign instruction_address_o = hazard_i ? replay_pc_i : pc_q;

    ////////////////////////////////////////////////////////////
    // PC, tag and outstanding fetch
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q        <= RESET_PC;
            tag_q       <= '0;
            fetch_o.pc  <= RESET_PC;
            // Mismatching tag kills whatever memory returns first
            fetch_o.tag <= '1;
        end
        else if (!stall_i) begin
            fetch_o.pc <= instruction_address_o;
            if (jump_i) begin
                pc_q        <= jump_target_i;
                // Fetch in flight gets an in-between tag
                // Both younger instructions then miss in execute
                fetch_o.tag <= tag_q + TAG_W'(1);
                tag_q       <= tag_q + TAG_W'(2);
            end
            else begin
                fetch_o.tag <= tag_q;
                // Hold on hazard, pc_q is already one past the replay
                if (!hazard_i) begin
                    pc_q <= pc_q + XLEN'(4);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode.sv ====
/*
 * Decode stage
 *   Opcode and funct decode to op_e, immediate forming
 *   Operand selection for the execute stage
 *   Hazard detection against execute and decode/execute register
 */
`default_nettype none

module decode
    import rv_core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  logic [XLEN-1:0]       instruction_i,
    input  fetch_out_t            fetch_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  hazard_o,
    output exec_in_t              exec_o
);

    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_s;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_j;
    op_e                   op;
    logic                  use_rs1;
    logic                  use_rs2;
    exec_in_t              exec_d;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];
    assign rd     = instruction_i[11:7];
    assign rs1_o  = instruction_i[19:15];
    assign rs2_o  = instruction_i[24:20];

    // Sign extended immediates
    assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_b = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                    instruction_i[30:25], instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};
    assign imm_j = {{11{instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                    instruction_i[20], instruction_i[30:21], 1'b0};

    // Operation decode, unknown encodings fall to OP_NOP
    always_comb begin
        op      = OP_NOP;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode_e'(instruction_i[6:0]))
            OPC_REG: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op = OP_ADD;
                    {7'b0100000, 3'b000}: op = OP_SUB;
                    {7'b0000000, 3'b111}: op = OP_AND;
                    {7'b0000000, 3'b110}: op = OP_OR;
                    {7'b0000000, 3'b100}: op = OP_XOR;
                    {7'b0000000, 3'b010}: op = OP_SLT;
                    default:              op = OP_NOP;
                endcase
            end
            OPC_IMM: begin
                use_rs1 = 1'b1;
                if (funct3 == 3'b000) begin
                    op = OP_ADDI;
                end
            end
            OPC_LUI: begin
                op = OP_LUI;
            end
            OPC_LOAD: begin
                use_rs1 = 1'b1;
                if (funct3 == 3'b010) begin
                    op = OP_LW;
                end
            end
            OPC_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct3 == 3'b010) begin
                    op = OP_SW;
                end
            end
            OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct3 == 3'b000) begin
                    op = OP_BEQ;
                end
                else if (funct3 == 3'b001) begin
                    op = OP_BNE;
                end
            end
            OPC_JAL: begin
                op = OP_JAL;
            end
            default: begin
                op = OP_NOP;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////

    // rd stays zero for ops that never write the register bank
    always_comb begin
        exec_d.valid      = 1'b1;
        exec_d.op         = op;
        exec_d.rd         = '0;
        exec_d.op1        = rs1_data_i;
        exec_d.op2        = rs2_data_i;
        exec_d.store_data = rs2_data_i;
        exec_d.pc         = fetch_i.pc;
        exec_d.tag        = fetch_i.tag;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
                exec_d.rd = rd;
            end
            OP_ADDI, OP_LW: begin
                exec_d.rd  = rd;
                exec_d.op2 = imm_i;
            end
            OP_LUI: begin
                exec_d.rd  = rd;
                exec_d.op1 = '0;
                exec_d.op2 = imm_u;
            end
            OP_SW: begin
                exec_d.op2 = imm_s;
            end
            OP_BEQ, OP_BNE: begin
                // Adder builds the target, compare result rides in store_data
                exec_d.op1        = fetch_i.pc;
                exec_d.op2        = imm_b;
                exec_d.store_data = rs1_data_i ^ rs2_data_i;
            end
            OP_JAL: begin
                exec_d.rd  = rd;
                exec_d.op1 = fetch_i.pc;
                exec_d.op2 = imm_j;
            end
            default: begin
                exec_d.rd = '0;
            end
        endcase
    end

    // Producer in execute, same tag means it is on the live path
    assign hazard_o = exec_o.valid && (exec_o.rd != '0) && (exec_o.tag == fetch_i.tag)
                      && ((use_rs1 && rs1_o == exec_o.rd) || (use_rs2 && rs2_o == exec_o.rd));

    // Decode/execute register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            exec_o <= '0;
        end
        else if (!stall_i) begin
            if (hazard_o) begin
                // Bubble while fetch replays this instruction
                exec_o <= '0;
            end
            else begin
                exec_o <= exec_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/regbank.sv ====
/*
 * Register bank
 *   Thirty-one flop registers, x0 hardwired to zero
 *   Two combinational read ports with retire write bypass
 */
`default_nettype none

module regbank
    import rv_core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  wb_t                   wb_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    // Writes to x0 dropped here
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wb_i.we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Read with bypass of the retiring value
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_i.we && wb_i.rd == idx) begin
            return wb_i.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

// ==== rtl/execute.sv ====
/*
 * Execute stage
 *   Tag check against the fetch tag to kill wrong-path work
 *   ALU, branch condition and JAL link address
 *   Data memory request and execute/retire register
 */
`default_nettype none

module execute
    import rv_core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  exec_in_t              exec_i,
    input  logic [TAG_W-1:0]      fetch_tag_i,
    output logic                  jump_o,
    output logic [XLEN-1:0]       jump_target_o,
    output mem_req_t              mem_o,
    output logic                  retire_valid_o,
    output op_e                   retire_op_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       result_o
);

    logic            live;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] result;
    logic            taken;

    // Stale tag means a younger jump has already redirected fetch
    assign live = exec_i.valid && (exec_i.tag == fetch_tag_i);

    // Shared adder
    // ADD, ADDI, LUI, memory address, branch and JAL target
    assign sum = exec_i.op1 + exec_i.op2;

    ////////////////////////////////////////////////////////////
    // ALU and branch
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (exec_i.op)
            OP_SUB:  result = exec_i.op1 - exec_i.op2;
            OP_AND:  result = exec_i.op1 & exec_i.op2;
            OP_OR:   result = exec_i.op1 | exec_i.op2;
            OP_XOR:  result = exec_i.op1 ^ exec_i.op2;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(exec_i.op1) < $signed(exec_i.op2)};
            OP_JAL:  result = exec_i.pc + XLEN'(4);
            default: result = sum;
        endcase
    end

    // Operands equal when their xor from decode is zero
    always_comb begin
        case (exec_i.op)
            OP_BEQ:  taken = (exec_i.store_data == '0);
            OP_BNE:  taken = (exec_i.store_data != '0);
            OP_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign jump_o        = live && taken;
    assign jump_target_o = sum;

    // Word access only
    always_comb begin
        mem_o.read_en  = live && (exec_i.op == OP_LW);
        mem_o.write_en = live && (exec_i.op == OP_SW);
        mem_o.addr     = sum;
        mem_o.wdata    = exec_i.store_data;
    end

    ////////////////////////////////////////////////////////////
    // Execute/retire register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_valid_o <= 1'b0;
            retire_op_o    <= OP_NOP;
            retire_rd_o    <= '0;
        end
        else if (!stall_i) begin
            retire_valid_o <= live;
            retire_op_o    <= exec_i.op;
            retire_rd_o    <= exec_i.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o <= result;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
/*
 * Core top level
 *   Fetch, decode, register bank and execute instances
 *   Retire write data select between load data and result
 *   Instruction and data memory port outputs
 */
`default_nettype none

module rv_core
    import rv_core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
)
(
    input  logic            clk,
    input  logic            rst_i,
    input  logic            stall_i,
    input  logic [XLEN-1:0] instruction_i,
    input  logic [XLEN-1:0] mem_data_i,
    output logic [XLEN-1:0] instruction_address_o,
    output logic            mem_operation_enable_o,
    output logic [3:0]      mem_write_enable_o,
    output logic [XLEN-1:0] mem_address_o,
    output logic [XLEN-1:0] mem_data_o
);

    // Stage links
    fetch_out_t            fetch_out;
    exec_in_t              exec_in;
    mem_req_t              mem_req;
    wb_t                   wb;
    logic                  hazard;
    logic                  jump;
    logic [XLEN-1:0]       jump_target;

    // Register bank ports
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    // Retire stage
    logic                  retire_valid;
    op_e                   retire_op;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       result;

    ////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////

    fetch #(
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .stall_i               (stall_i),
        .hazard_i              (hazard),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .replay_pc_i           (fetch_out.pc),
        .instruction_address_o (instruction_address_o),
        .fetch_o               (fetch_out)
    );

    decode decode_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .fetch_i       (fetch_out),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .hazard_o      (hazard),
        .exec_o        (exec_in)
    );

    regbank regbank_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // Tag of the instruction in decode is the live tag
    execute execute_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .stall_i        (stall_i),
        .exec_i         (exec_in),
        .fetch_tag_i    (fetch_out.tag),
        .jump_o         (jump),
        .jump_target_o  (jump_target),
        .mem_o          (mem_req),
        .retire_valid_o (retire_valid),
        .retire_op_o    (retire_op),
        .retire_rd_o    (retire_rd),
        .result_o       (result)
    );

    ////////////////////////////////////////////////////////////
    // Retire and memory ports
    ////////////////////////////////////////////////////////////

    // Load data arrives in the retire cycle
    always_comb begin
        wb.we   = retire_valid;
        wb.rd   = retire_rd;
        wb.data = (retire_op == OP_LW) ? mem_data_i : result;
    end

    assign mem_operation_enable_o = mem_req.read_en | mem_req.write_en;
    assign mem_write_enable_o     = {4{mem_req.write_en}};
    assign mem_address_o          = mem_req.addr;
    assign mem_data_o             = mem_req.wdata;

endmodule

`default_nettype wire

// ==== testbench/rv_core_properties.sv ====
/*
 * Concurrent assertions on the core's memory ports
 *   Memory enable quiet during reset
 *   Outputs frozen across a stalled cycle
 *   Word-aligned requests with all or no write lanes
 */
`default_nettype none

module rv_core_properties
    import rv_core_pkg::*;
(
    input logic            clk,
    input logic            rst_i,
    input logic            stall_i,
    input logic [XLEN-1:0] instruction_address_o,
    input logic            mem_operation_enable_o,
    input logic [3:0]      mem_write_enable_o,
    input logic [XLEN-1:0] mem_address_o,
    input logic [XLEN-1:0] mem_data_o
);

    // Registers are cleared only from the second reset edge on
    assert property (@(posedge clk) rst_i && $past(rst_i) |-> !mem_operation_enable_o)
        else $error("Memory enable high while in reset");

    // Every register holds on a stalled edge
    assert property (@(posedge clk) disable iff (rst_i)
        stall_i |=> $stable({instruction_address_o, mem_operation_enable_o,
                             mem_write_enable_o, mem_address_o, mem_data_o}))
        else $error("Core outputs moved across a stalled cycle");

    // Word access only
    assert property (@(posedge clk) disable iff (rst_i)
        mem_operation_enable_o |-> (mem_address_o[1:0] == 2'b00)
                                   && (mem_write_enable_o inside {4'b0000, 4'b1111}))
        else $error("Misaligned address %h or partial write enable %b",
                    mem_address_o, mem_write_enable_o);

endmodule

`default_nettype wire

// ==== testbench/tb_rv_core.sv ====
/*
 * Testbench for the four-stage RV32I core
 *   Clock, reset and random global stall
 *   One-cycle instruction and data memory models
 *   Golden file loader, store checker and watchdog
 */
`default_nettype none

module tb_rv_core
    import rv_core_pkg::*;
;

    localparam int MEM_WORDS  = 256;
    localparam int CYCLES_PER = 40;

    logic            clk;
    logic            rst_i;
    logic            stall_i;
    logic [XLEN-1:0] instruction_i;
    logic [XLEN-1:0] mem_data_i;
    logic [XLEN-1:0] instruction_address_o;
    logic            mem_operation_enable_o;
    logic [3:0]      mem_write_enable_o;
    logic [XLEN-1:0] mem_address_o;
    logic [XLEN-1:0] mem_data_o;

    // Memories and expected store sequence
    logic [XLEN-1:0] imem [0:MEM_WORDS-1];
    logic [XLEN-1:0] dmem [0:MEM_WORDS-1];
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    int              n_instr;
    int              n_stores;
    int              store_count;
    logic            loaded;

    rv_core #(
        .RESET_PC (32'h0000_0000)
    ) rv_core_i (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .mem_data_i             (mem_data_i),
        .instruction_address_o  (instruction_address_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

    bind rv_core rv_core_properties props_i (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .stall_i                (stall_i),
        .instruction_address_o  (instruction_address_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

    ////////////////////////////////////////////////////////////
    // Failure handling and checks
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Low two bits 00 never form a valid opcode, so unused words act as NOPs
    task automatic fill_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = 32'(i) << 2;
            dmem[i] = 32'hD000_0000 | (32'(i) << 2);
        end
    endtask

    // Each line holds a kind, a hex address and a hex word
    task automatic load_golden();
        int              fd;
        string           line;
        logic [7:0]      kind;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        fd = $fopen("testbench/golden_program.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file testbench/golden_program.txt");
            stop_with_failure();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 3 || line.getc(0) == "#") begin
                continue;
            end
            kind = line.getc(0);
            void'($sscanf(line.substr(2, line.len() - 1), "%h %h", a, d));
            if (kind == "I") begin
                imem[a[9:2]] = d;
                n_instr++;
            end
            else if (kind == "D") begin
                dmem[a[9:2]] = d;
            end
            else if (kind == "S") begin
                exp_addr.push_back(a);
                exp_data.push_back(d);
            end
        end
        $fclose(fd);
        n_stores = exp_data.size();
        if (n_instr == 0 || n_stores == 0) begin
            $display("Golden file holds no program or no expected stores");
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, reset and stall
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_i         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = '0;
        mem_data_i    = '0;
        n_instr       = 0;
        n_stores      = 0;
        store_count   = 0;
        loaded        = 1'b0;
        void'($urandom(75));
        fill_memories();
        load_golden();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        wait (store_count == n_stores);
        // Quiet tail catches any store past the sequence
        repeat (10) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

    // Roughly one stalled cycle in five
    always @(posedge clk) begin
        if (rst_i) begin
            stall_i <= 1'b0;
        end
        else begin
            stall_i <= ($urandom % 100) < 20;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory models and store checker
    ////////////////////////////////////////////////////////////

    // Responses hold while the core is stalled
    always @(posedge clk) begin
        if (!stall_i) begin
            instruction_i <= imem[instruction_address_o[9:2]];
            mem_data_i    <= dmem[mem_address_o[9:2]];
        end
    end

    // Any write lane starts a store, word stores use all four lanes
    always @(posedge clk) begin
        if (!rst_i && !stall_i && mem_write_enable_o != 4'b0000) begin
            if (store_count >= n_stores) begin
                $display("Unexpected store to %08h after the last expected one", mem_address_o);
                stop_with_failure();
            end
            else begin
                check_value($sformatf("store %0d enable", store_count),
                            32'h0000_0001, 32'(mem_operation_enable_o));
                check_value($sformatf("store %0d write lanes", store_count),
                            32'h0000_000F, 32'(mem_write_enable_o));
                check_value($sformatf("store %0d address", store_count),
                            exp_addr[store_count], mem_address_o);
                check_value($sformatf("store %0d data", store_count),
                            exp_data[store_count], mem_data_o);
                dmem[mem_address_o[9:2]] <= mem_data_o;
                store_count <= store_count + 1;
            end
        end
    end

    // Limit scales with program length
    initial begin
        wait (loaded);
        repeat (n_instr * CYCLES_PER) @(posedge clk);
        $display("Watchdog expired with %0d of %0d stores seen", store_count, n_stores);
        stop_with_failure();
    end

endmodule

`default_nettype wire

// ==== testbench/golden_program.txt ====
# Columns: kind, hex address, hex word
# I = program word, D = data preload, S = expected store (address, data) in order
I 00000000 5A300093
I 00000004 F0F00113
I 00000008 002081B3
I 0000000C 20302023
I 00000010 40208233
I 00000014 0020F2B3
I 00000018 20402223
I 0000001C 0020E333
I 00000020 0020C3B3
I 00000024 20502423
I 00000028 20602623
I 0000002C 20702823
I 00000030 00112433
I 00000034 0020A4B3
I 00000038 20802A23
I 0000003C 20902C23
I 00000040 ABCDE637
I 00000044 12360693
I 00000048 20D02E23
I 0000004C 10000513
I 00000050 00452703
I 00000054 22E02023
I 00000058 00052783
I 0000005C 00E78833
I 00000060 01052423
I 00000064 00208463
I 00000068 22102223
I 0000006C 00209463
I 00000070 22202423
I 00000074 00318663
I 00000078 22302623
I 0000007C 22302823
I 00000080 00109463
I 00000084 00C008EF
I 00000088 22402A23
I 0000008C 22402C23
I 00000090 23102623
I 00000094 07700013
I 00000098 22002823
I 0000009C 0000006F
D 00000100 11223344
D 00000104 0F0F0F0F
S 00000200 000004B2
S 00000204 00000694
S 00000208 00000503
S 0000020C FFFFFFAF
S 00000210 FFFFFAAC
S 00000214 00000001
S 00000218 00000000
S 0000021C ABCDE123
S 00000220 0F0F0F0F
S 00000108 20314253
S 00000224 000005A3
S 0000022C 00000088
S 00000230 00000000

// ==== src.f ====
rtl/rv_core_pkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/regbank.sv
rtl/execute.sv
rtl/rv_core.sv
testbench/rv_core_properties.sv
testbench/tb_rv_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_rv_core
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
